//--- memSystem.f
+incdir+.
memPkg.sv
instrCache.sv
dataCache.sv
busArbiter.sv
ahbMemory.sv
memSystem.sv
memSystemTb.sv

//--- run.sh
#!/bin/sh
# Builds the memory system testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module memSystemTb -f memSystem.f -o memSystemSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/memSystemSim > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "Simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0

//--- memSystemTb.sv
// Directed testbench for the cache and bus memory system, with compare tasks and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "memSystem_settings.svh"

module memSystemTb
  import memPkg::*;
();

  localparam int ClkPeriod    = 10;
  localparam int ResetCycles  = 10;
  localparam int IndexBits    = $clog2(`MEM_WORDS);
  localparam int RandomRounds = 8;
  // Reads and stores issued by all tests together
  localparam int NumAccesses  = 12 + 2 * RandomRounds;
  localparam int LimitCycles  =
    NumAccesses * `BLOCK_WORDS * (`MEM_WAIT_STATES + 1) * 4 + ResetCycles;

  logic     clk;
  logic     reset;
  logic     invalidateInstr;
  logic     invalidateData;
  addrT     instrAddr;
  logic     instrRequest;
  wordT     instrData;
  logic     instrStall;
  addrT     dataAddr;
  logic     dataRequest;
  logic     dataWrite;
  wordT     dataWriteData;
  byteMaskT dataByteMask;
  wordT     dataReadData;
  logic     dataStall;

  wordT        shadow [`MEM_WORDS];
  logic [31:0] lcgState = 32'd94170;
  int          checkCount = 0;
  int          errorCount = 0;

  memSystem memSystem_i (.*);

  always #(ClkPeriod / 2) clk = ~clk;

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  // Word-aligned address inside the modelled memory
  function automatic addrT randomAddr();
    logic [31:0] r;
    r = nextRandom();
    return {{(30 - IndexBits){1'b0}}, r[IndexBits+15:16], 2'b00};
  endfunction

  function automatic wordT expectedWord(input addrT addr);
    return shadow[addr[IndexBits+1:2]];
  endfunction

  task automatic checkWord(input string name, input wordT actual, input wordT expected);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic checkStall(input string name, input logic actual, input logic expected);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
    end
  endtask

  task automatic readInstr(input addrT addr, input logic expectStall);
    @(posedge clk);
    #1;
    instrAddr    = addr;
    instrRequest = 1'b1;
    @(negedge clk);
    checkStall("instrStall", instrStall, expectStall);
    while (instrStall)
      @(negedge clk);
    checkWord("instrData", instrData, expectedWord(addr));
    @(posedge clk);
    #1;
    instrRequest = 1'b0;
  endtask

  task automatic readData(input addrT addr, input logic expectStall);
    @(posedge clk);
    #1;
    dataAddr    = addr;
    dataWrite   = 1'b0;
    dataRequest = 1'b1;
    @(negedge clk);
    checkStall("dataStall", dataStall, expectStall);
    while (dataStall)
      @(negedge clk);
    checkWord("dataReadData", dataReadData, expectedWord(addr));
    @(posedge clk);
    #1;
    dataRequest = 1'b0;
  endtask

  // Every store stalls until its bus beat is done
  task automatic writeData(input addrT addr, input wordT data, input byteMaskT mask);
    @(posedge clk);
    #1;
    dataAddr      = addr;
    dataWrite     = 1'b1;
    dataWriteData = data;
    dataByteMask  = mask;
    dataRequest   = 1'b1;
    @(negedge clk);
    checkStall("dataStall", dataStall, 1'b1);
    while (dataStall)
      @(negedge clk);
    for (int b = 0; b < 4; b++)
      if (mask[b])
        shadow[addr[IndexBits+1:2]][8*b +: 8] = data[8*b +: 8];
    @(posedge clk);
    #1;
    dataRequest = 1'b0;
    dataWrite   = 1'b0;
  endtask

  task automatic pulseInvalidate(input logic instrSide);
    @(posedge clk);
    #1;
    invalidateInstr = instrSide;
    invalidateData  = !instrSide;
    @(posedge clk);
    #1;
    invalidateInstr = 1'b0;
    invalidateData  = 1'b0;
  endtask

  // Both ports start in the same cycle and each finishes on its own
  task automatic readBoth(input addrT iAddr, input addrT dAddr);
    logic instrDone;
    logic dataDone;
    instrDone = 1'b0;
    dataDone  = 1'b0;
    @(posedge clk);
    #1;
    instrAddr    = iAddr;
    instrRequest = 1'b1;
    dataAddr     = dAddr;
    dataWrite    = 1'b0;
    dataRequest  = 1'b1;
    while (!(instrDone && dataDone))
    begin
      @(negedge clk);
      if (!instrDone && !instrStall)
      begin
        checkWord("instrData", instrData, expectedWord(iAddr));
        instrDone = 1'b1;
      end
      if (!dataDone && !dataStall)
      begin
        checkWord("dataReadData", dataReadData, expectedWord(dAddr));
        dataDone = 1'b1;
      end
      @(posedge clk);
      #1;
      if (instrDone)
        instrRequest = 1'b0;
      if (dataDone)
        dataRequest = 1'b0;
    end
  endtask

  // Ends a run that stops making progress
  initial
  begin
    #(LimitCycles * ClkPeriod);
    $display("Timeout after %0d cycles, an access never completed", LimitCycles);
    $display("Test failed");
    $finish;
  end

  initial
  begin
    clk             = 1'b0;
    reset           = 1'b1;
    invalidateInstr = 1'b0;
    invalidateData  = 1'b0;
    instrAddr       = '0;
    instrRequest    = 1'b0;
    dataAddr        = '0;
    dataRequest     = 1'b0;
    dataWrite       = 1'b0;
    dataWriteData   = '0;
    dataByteMask    = '0;
    for (int i = 0; i < `MEM_WORDS; i++)
      shadow[i] = wordT'(i << 2) ^ `MEM_FILL;
    repeat (ResetCycles) @(posedge clk);
    #1;
    reset = 1'b0;

    // Instruction miss, then hits across the line
    readInstr(32'h0000_0100, 1'b1);
    for (int w = 1; w < `BLOCK_WORDS; w++)
      readInstr(32'h0000_0100 + addrT'(4 * w), 1'b0);

    // Data miss, then a hit in the same line
    readData(32'h0000_0804, 1'b1);
    readData(32'h0000_0808, 1'b0);

    // Masked store to a cached word
    writeData(32'h0000_080C, 32'hA1B2_C3D4, 4'b0101);
    readData(32'h0000_080C, 1'b0);

    // Store miss does not allocate
    writeData(32'h0000_1A04, 32'h5566_7788, 4'b1100);
    readData(32'h0000_1A04, 1'b1);

    // Invalidate each cache and read again
    pulseInvalidate(1'b1);
    readInstr(32'h0000_0104, 1'b1);
    pulseInvalidate(1'b0);
    readData(32'h0000_080C, 1'b1);

    // Simultaneous traffic on both ports
    for (int r = 0; r < RandomRounds; r++)
      readBoth(randomAddr(), randomAddr());

    repeat (2) @(posedge clk);
    $display("Checks run: %0d, mismatches: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- memSystem.sv
// Top level with both caches, the bus arbiter and the memory model
`timescale 1ns/1ps
`default_nettype none

module memSystem
  import memPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     invalidateInstr,
  input  logic     invalidateData,
  input  addrT     instrAddr,
  input  logic     instrRequest,
  output wordT     instrData,
  output logic     instrStall,
  input  addrT     dataAddr,
  input  logic     dataRequest,
  input  logic     dataWrite,
  input  wordT     dataWriteData,
  input  byteMaskT dataByteMask,
  output wordT     dataReadData,
  output logic     dataStall
);

  // Cache to arbiter
  logic     instrBusRequest, instrBusReady;
  addrT     instrBusAddr;
  logic     dataBusRequest, dataBusReady, dataBusWrite;
  addrT     dataBusAddr;
  wordT     dataBusWriteData;
  byteMaskT dataBusByteMask;

  // Shared bus
  logic     HRequest, HReady, HWrite;
  addrT     HAddr;
  wordT     HWData, HRData;
  byteMaskT HByteMask;

  instrCache instrCache_i (
    .invalidate(invalidateInstr),
    .busReady  (instrBusReady  ),
    .busAddr   (instrBusAddr   ),
    .busRequest(instrBusRequest),
    .*
  );

  dataCache dataCache_i (
    .invalidate  (invalidateData  ),
    .busReady    (dataBusReady    ),
    .busAddr     (dataBusAddr     ),
    .busRequest  (dataBusRequest  ),
    .busWrite    (dataBusWrite    ),
    .busWriteData(dataBusWriteData),
    .busByteMask (dataBusByteMask ),
    .*
  );

  busArbiter busArbiter_i (.*);

  ahbMemory ahbMemory_i (.*);

endmodule

`default_nettype wire

//--- ahbMemory.sv
// Word memory on the bus with a preset fill pattern and fixed wait states
`timescale 1ns/1ps
`default_nettype none

`include "memSystem_settings.svh"

module ahbMemory
  import memPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  addrT     HAddr,
  input  logic     HRequest,
  input  logic     HWrite,
  input  wordT     HWData,
  input  byteMaskT HByteMask,
  output wordT     HRData,
  output logic     HReady
);

  localparam int IndexBits = $clog2(`MEM_WORDS);
  localparam int CountBits = $clog2(`MEM_WAIT_STATES + 2);

  wordT mem [`MEM_WORDS];
  logic [IndexBits-1:0] wordIndex;
  logic [CountBits-1:0] waitCount;

  // Upper address bits alias onto the array
  assign wordIndex = HAddr[IndexBits+1:2];
  assign HRData    = mem[wordIndex];

  // Beat completes once the wait states have passed
  assign HReady = HRequest && (waitCount == CountBits'(`MEM_WAIT_STATES));

  always_ff @(posedge clk)
  begin
    if (reset || !HRequest || HReady)
      waitCount <= '0;
    else
      waitCount <= waitCount + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < `MEM_WORDS; i++)
        mem[i] <= wordT'(i << 2) ^ `MEM_FILL;
    end
    else if (HReady && HWrite)
    begin
      // Only the enabled lanes change
      for (int b = 0; b < 4; b++)
        if (HByteMask[b])
          mem[wordIndex][8*b +: 8] <= HWData[8*b +: 8];
    end
  end

endmodule

`default_nettype wire

//--- busArbiter.sv
// Two-way bus arbiter between the data cache and the instruction cache
`timescale 1ns/1ps
`default_nettype none

module busArbiter
  import memPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     instrBusRequest,
  input  addrT     instrBusAddr,
  input  logic     dataBusRequest,
  input  addrT     dataBusAddr,
  input  logic     dataBusWrite,
  input  wordT     dataBusWriteData,
  input  byteMaskT dataBusByteMask,
  input  logic     HReady,
  output logic     instrBusReady,
  output logic     dataBusReady,
  output addrT     HAddr,
  output logic     HRequest,
  output logic     HWrite,
  output wordT     HWData,
  output byteMaskT HByteMask
);

  busOwnerT owner;
  busOwnerT current;
  logic granted;
  logic dataSel;

  // A held grant wins, else the data side goes first
  always_comb
  begin
    if (granted)
      current = owner;
    else if (dataBusRequest)
      current = ownerData;
    else
      current = ownerInstr;
  end

  assign dataSel = (current == ownerData);

  assign HRequest  = dataSel ? dataBusRequest : instrBusRequest;
  assign HAddr     = dataSel ? dataBusAddr : instrBusAddr;
  assign HWrite    = dataSel && dataBusWrite;
  assign HWData    = dataSel ? dataBusWriteData : '0;
  assign HByteMask = dataSel ? dataBusByteMask : '1;

  // Only the owner sees the memory handshake
  assign instrBusReady = HReady && !dataSel;
  assign dataBusReady  = HReady && dataSel;

  // Grant lasts until the owner lets its request go
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      granted <= 1'b0;
      owner   <= ownerInstr;
    end
    else if (!granted && HRequest)
    begin
      granted <= 1'b1;
      owner   <= current;
    end
    else if (granted && !HRequest)
      granted <= 1'b0;
  end

endmodule

`default_nettype wire

//--- dataCache.sv
// Direct-mapped write-through data cache with byte-masked stores and line fill
`timescale 1ns/1ps
`default_nettype none

`include "memSystem_settings.svh"

module dataCache
  import memPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     invalidate,
  input  addrT     dataAddr,
  input  logic     dataRequest,
  input  logic     dataWrite,
  input  wordT     dataWriteData,
  input  byteMaskT dataByteMask,
  input  logic     busReady,
  input  wordT     HRData,
  output wordT     dataReadData,
  output logic     dataStall,
  output addrT     busAddr,
  output logic     busRequest,
  output logic     busWrite,
  output wordT     busWriteData,
  output byteMaskT busByteMask
);

  localparam int WordBits = $clog2(`BLOCK_WORDS);
  localparam int LineBits = $clog2(`CACHE_LINES);
  localparam int TagLsb   = LineBits + WordBits + 2;
  localparam int TagBits  = 32 - TagLsb;

  cacheStateT state;
  logic [`CACHE_LINES-1:0] valid;
  logic [TagBits-1:0] tagArray [`CACHE_LINES];
  wordT dataArray [`CACHE_LINES*`BLOCK_WORDS];

  logic [LineBits-1:0] line;
  logic [TagBits-1:0]  tag;
  logic [WordBits-1:0] fillWord;
  logic hit;
  logic lastBeat;
  logic writeDone;

  assign line = dataAddr[TagLsb-1:WordBits+2];
  assign tag  = dataAddr[31:TagLsb];
  assign hit  = valid[line] && (tagArray[line] == tag);

  assign dataReadData = dataArray[dataAddr[TagLsb-1:2]];

  // Stores wait for their beat, loads wait for a hit
  assign dataStall = dataRequest &&
                     ((state != stateIdle) || (dataWrite ? !writeDone : !hit));

  // Bus side, one write beat or a full line read
  assign busRequest   = (state != stateIdle);
  assign busWrite     = (state == stateWrite);
  assign busWriteData = dataWriteData;
  assign busByteMask  = dataByteMask;
  assign busAddr      = busWrite ? {dataAddr[31:2], 2'b00}
                                 : {dataAddr[31:WordBits+2], fillWord, 2'b00};
  assign lastBeat     = busReady && (fillWord == WordBits'(`BLOCK_WORDS - 1));

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state     <= stateIdle;
      valid     <= '0;
      fillWord  <= '0;
      writeDone <= 1'b0;
    end
    else
    begin
      // Lets the held store complete in the cycle after its beat
      writeDone <= busWrite && busReady;
      case (state)
        stateIdle:
        begin
          if (invalidate)
            valid <= '0;
          else if (dataRequest && dataWrite && !writeDone)
            state <= stateWrite;
          else if (dataRequest && !dataWrite && !hit)
            state <= stateFill;
        end
        stateFill:
        begin
          if (busReady)
            fillWord <= lastBeat ? '0 : fillWord + 1'b1;
          if (lastBeat)
          begin
            valid[line] <= 1'b1;
            state       <= stateIdle;
          end
        end
        stateWrite:
        begin
          if (busReady)
            state <= stateIdle;
        end
        default:
          state <= stateIdle;
      endcase
    end
  end

  // Fill beats and store merges; a store miss leaves the arrays alone
  always_ff @(posedge clk)
  begin
    if (state == stateFill && busReady)
      dataArray[{line, fillWord}] <= HRData;
    if (state == stateFill && lastBeat)
      tagArray[line] <= tag;
    if (busWrite && busReady && hit)
    begin
      for (int b = 0; b < 4; b++)
        if (dataByteMask[b])
          dataArray[dataAddr[TagLsb-1:2]][8*b +: 8] <= dataWriteData[8*b +: 8];
    end
  end

endmodule

`default_nettype wire

//--- instrCache.sv
// Direct-mapped read-only instruction cache with line fill over the bus
`timescale 1ns/1ps
`default_nettype none

`include "memSystem_settings.svh"

module instrCache
  import memPkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic invalidate,
  input  addrT instrAddr,
  input  logic instrRequest,
  input  logic busReady,
  input  wordT HRData,
  output wordT instrData,
  output logic instrStall,
  output addrT busAddr,
  output logic busRequest
);

  localparam int WordBits = $clog2(`BLOCK_WORDS);
  localparam int LineBits = $clog2(`CACHE_LINES);
  localparam int TagLsb   = LineBits + WordBits + 2;
  localparam int TagBits  = 32 - TagLsb;

  cacheStateT state;
  logic [`CACHE_LINES-1:0] valid;
  logic [TagBits-1:0] tagArray [`CACHE_LINES];
  wordT dataArray [`CACHE_LINES*`BLOCK_WORDS];

  logic [LineBits-1:0] line;
  logic [TagBits-1:0]  tag;
  logic [WordBits-1:0] fillWord;
  logic hit;
  logic lastBeat;

  // Fields of the fetch address
  assign line = instrAddr[TagLsb-1:WordBits+2];
  assign tag  = instrAddr[31:TagLsb];
  assign hit  = valid[line] && (tagArray[line] == tag);

  // Hit word comes straight out of the array
  assign instrData  = dataArray[instrAddr[TagLsb-1:2]];
  assign instrStall = instrRequest && ((state != stateIdle) || !hit);

  // Fill walks the line from word 0 upward
  assign busRequest = (state == stateFill);
  assign busAddr    = {instrAddr[31:WordBits+2], fillWord, 2'b00};
  assign lastBeat   = busReady && (fillWord == WordBits'(`BLOCK_WORDS - 1));

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state    <= stateIdle;
      valid    <= '0;
      fillWord <= '0;
    end
    else
    begin
      case (state)
        stateIdle:
        begin
          if (invalidate)
            valid <= '0;
          else if (instrRequest && !hit)
            state <= stateFill;
        end
        stateFill:
        begin
          if (busReady)
            fillWord <= lastBeat ? '0 : fillWord + 1'b1;
          if (lastBeat)
          begin
            valid[line] <= 1'b1;
            state       <= stateIdle;
          end
        end
        default:
          state <= stateIdle;
      endcase
    end
  end

  // Line data and tag storage
  always_ff @(posedge clk)
  begin
    if (busRequest && busReady)
      dataArray[{line, fillWord}] <= HRData;
    if (busRequest && lastBeat)
      tagArray[line] <= tag;
  end

endmodule

`default_nettype wire

//--- memPkg.sv
// Address, data word, byte mask, bus owner and cache state types
`default_nettype none

package memPkg;

  // Byte address and data word
  typedef logic [31:0] addrT;
  typedef logic [31:0] wordT;

  // One enable per byte lane, bit 0 covers bits 7:0
  typedef logic [3:0] byteMaskT;

  // Master holding the shared bus
  typedef enum logic
  {
    ownerInstr,
    ownerData
  } busOwnerT;

  // Cache controller states
  typedef enum logic [1:0]
  {
    stateIdle,
    stateFill,
    stateWrite
  } cacheStateT;

endpackage

`default_nettype wire

//--- memSystem_settings.svh
// Cache geometry, memory depth, wait states and memory fill pattern
`ifndef MEM_SYSTEM_SETTINGS_SVH
`define MEM_SYSTEM_SETTINGS_SVH

// Lines in each cache
`define CACHE_LINES 64

// Words per cache line
`define BLOCK_WORDS 4

// Memory depth in words
`define MEM_WORDS 4096

// Cycles HReady stays low before a beat completes
`define MEM_WAIT_STATES 2

// Word at byte address A starts out as A ^ MEM_FILL
`define MEM_FILL 32'h3C5A_96F0

`endif
